// File: rtl/pf_pkg.sv
package pf_pkg;

    localparam int addr_w  = 32;
    localparam int idx_w   = 6;
    localparam int idx_lsb = 2;

    localparam logic [1:0] hit_init    = 2'b01;
    localparam logic [1:0] spare_init  = 2'b10;
    localparam logic [1:0] choice_init = 2'b01;

    // msb is the decision bit
    typedef logic [1:0] ctr_t;

    typedef struct packed {
        ctr_t hit;
        ctr_t spare;
        ctr_t choice;
    } pf_counters_t;

    typedef struct packed {
        logic [addr_w-1:0] pc;
        logic [addr_w-1:0] addr;
    } pf_access_t;

    // counters is the snapshot the prediction reported
    typedef struct packed {
        logic [addr_w-1:0] pc;
        logic [addr_w-1:0] addr;
        logic              hit;
        logic              spare;
        logic              choice;
        pf_counters_t      counters;
    } pf_update_t;

    typedef struct packed {
        logic [addr_w-1:0] pc;
        logic [addr_w-1:0] addr;
    } pf_anneal_t;

    typedef struct packed {
        logic [addr_w-1:0] pc;
        logic [addr_w-1:0] addr;
        logic              suppress;
    } pf_lookup_t;

    typedef struct packed {
        logic              we;
        logic [addr_w-1:0] pc;
        logic [addr_w-1:0] addr;
        pf_counters_t      counters;
    } pf_cwrite_t;

    typedef struct packed {
        logic [addr_w-1:0] addr;
        pf_counters_t      counters;
    } pf_pred_t;

    // saturating 2-bit step
    function automatic ctr_t ctr_step(ctr_t cur, logic taken);
        ctr_t nxt;
        nxt = cur;
        if (taken && cur != 2'b11) begin
            nxt = cur + 2'd1;
        end else if (!taken && cur != 2'b00) begin
            nxt = cur - 2'd1;
        end
        return nxt;
    endfunction

endpackage

// File: rtl/pf_table_ram.sv
`timescale 1ns/1ps

module pf_table_ram #(
    parameter int                data_w = 2,
    parameter logic [data_w-1:0] init   = '0
) (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic [pf_pkg::idx_w-1:0] raddr,
    output logic [data_w-1:0]        rdata,
    input  logic                     we,
    input  logic [pf_pkg::idx_w-1:0] waddr,
    input  logic [data_w-1:0]        wdata
);

    localparam int depth = 1 << pf_pkg::idx_w;

    logic [data_w-1:0] mem [depth];

    // read returns the entry as it was before a same-cycle write
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < depth; i++) begin
                mem[i] <= init;
            end
            rdata <= init;
        end else begin
            rdata <= mem[raddr];
            if (we) begin
                mem[waddr] <= wdata;
            end
        end
    end

endmodule

// File: rtl/pf_request_decode.sv
`timescale 1ns/1ps

module pf_request_decode (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 acc_valid,
    input  pf_pkg::pf_access_t   acc,
    input  logic                 upd_valid,
    input  pf_pkg::pf_update_t   upd,
    input  logic                 ann_valid,
    input  pf_pkg::pf_anneal_t   ann,
    input  pf_pkg::pf_counters_t rd_counters,
    output pf_pkg::pf_lookup_t   lookup,
    output pf_pkg::pf_cwrite_t   cwrite,
    output logic                 suppress_q
);

    logic               ann_pend_q;
    pf_pkg::pf_anneal_t ann_q;

    // anneal steals the counter lookup slot
    always_comb begin
        if (ann_valid) begin
            lookup.pc   = ann.pc;
            lookup.addr = ann.addr;
        end else begin
            lookup.pc   = acc.pc;
            lookup.addr = acc.addr;
        end
        lookup.suppress = ann_valid & acc_valid;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ann_pend_q <= 1'b0;
            suppress_q <= 1'b0;
        end else begin
            ann_pend_q <= ann_valid;
            suppress_q <= lookup.suppress;
        end
    end

    always_ff @(posedge clk) begin
        if (ann_valid) begin
            ann_q <= ann;
        end
    end

    // pending anneal write wins over an update
    always_comb begin
        if (ann_pend_q) begin
            cwrite.we              = 1'b1;
            cwrite.pc              = ann_q.pc;
            cwrite.addr            = ann_q.addr;
            cwrite.counters.hit    = pf_pkg::ctr_step(rd_counters.hit, 1'b0);
            cwrite.counters.spare  = pf_pkg::ctr_step(rd_counters.spare, 1'b1);
            cwrite.counters.choice = rd_counters.choice;
        end else begin
            cwrite.we              = upd_valid;
            cwrite.pc              = upd.pc;
            cwrite.addr            = upd.addr;
            cwrite.counters.hit    = pf_pkg::ctr_step(upd.counters.hit, upd.hit);
            cwrite.counters.spare  = pf_pkg::ctr_step(upd.counters.spare, upd.spare);
            cwrite.counters.choice = pf_pkg::ctr_step(upd.counters.choice, upd.choice);
        end
    end

endmodule

// File: rtl/pf_stride_table.sv
`timescale 1ns/1ps

module pf_stride_table (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      acc_valid,
    input  pf_pkg::pf_access_t        acc,
    output logic                      stride_valid,
    output logic [pf_pkg::addr_w-1:0] stride_addr
);

    localparam int entry_w = pf_pkg::addr_w + 1;

    logic [pf_pkg::idx_w-1:0]  pc_idx;
    logic [entry_w-1:0]        wdata;
    logic [entry_w-1:0]        rdata;
    logic [pf_pkg::addr_w-1:0] last_addr;
    logic [pf_pkg::addr_w-1:0] addr_q;

    assign pc_idx = acc.pc[pf_pkg::idx_lsb +: pf_pkg::idx_w];

    // entry is {last addr, valid}
    assign wdata = {acc.addr, 1'b1};

    pf_table_ram #(
        .data_w (entry_w),
        .init   ('0)
    ) last_ram_i (
        .clk    (clk),
        .arst_n (arst_n),
        .raddr  (pc_idx),
        .rdata  (rdata),
        .we     (acc_valid),
        .waddr  (pc_idx),
        .wdata  (wdata)
    );

    assign last_addr    = rdata[entry_w-1:1];
    assign stride_valid = rdata[0];

    // current addr, aligned with the registered read
    always_ff @(posedge clk) begin
        if (acc_valid) begin
            addr_q <= acc.addr;
        end
    end

    // addr + (addr - last)
    assign stride_addr = addr_q + (addr_q - last_addr);

endmodule

// File: rtl/pf_pointer_table.sv
`timescale 1ns/1ps

module pf_pointer_table (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      acc_valid,
    input  pf_pkg::pf_access_t        acc,
    output logic                      ptr_valid,
    output logic [pf_pkg::addr_w-1:0] ptr_addr
);

    localparam int entry_w = pf_pkg::addr_w + 1;

    logic [pf_pkg::addr_w-1:0] prev_addr_q;
    logic [pf_pkg::idx_w-1:0]  rd_idx;
    logic [pf_pkg::idx_w-1:0]  wr_idx;
    logic                      wr_en;
    logic [entry_w-1:0]        wdata;
    logic [entry_w-1:0]        rdata;

    assign rd_idx = acc.addr[pf_pkg::idx_lsb +: pf_pkg::idx_w];
    assign wr_idx = prev_addr_q[pf_pkg::idx_lsb +: pf_pkg::idx_w];

    // successor of prev addr is the current one
    assign wr_en = acc_valid && (acc.addr != prev_addr_q);
    assign wdata = {acc.addr, 1'b1};

    pf_table_ram #(
        .data_w (entry_w),
        .init   ('0)
    ) next_ram_i (
        .clk    (clk),
        .arst_n (arst_n),
        .raddr  (rd_idx),
        .rdata  (rdata),
        .we     (wr_en),
        .waddr  (wr_idx),
        .wdata  (wdata)
    );

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            prev_addr_q <= '0;
        end else if (acc_valid) begin
            prev_addr_q <= acc.addr;
        end
    end

    assign ptr_addr  = rdata[entry_w-1:1];
    assign ptr_valid = rdata[0];

endmodule

// File: rtl/pf_confidence_table.sv
`timescale 1ns/1ps

module pf_confidence_table (
    input  logic                 clk,
    input  logic                 arst_n,
    input  pf_pkg::pf_lookup_t   lookup,
    input  pf_pkg::pf_cwrite_t   cwrite,
    output pf_pkg::pf_counters_t counters
);

    logic [pf_pkg::idx_w-1:0] rd_addr_idx;
    logic [pf_pkg::idx_w-1:0] rd_pc_idx;
    logic [pf_pkg::idx_w-1:0] wr_addr_idx;
    logic [pf_pkg::idx_w-1:0] wr_pc_idx;
    pf_pkg::ctr_t             hit_rd;
    pf_pkg::ctr_t             spare_rd;
    pf_pkg::ctr_t             choice_rd;

    assign rd_addr_idx = lookup.addr[pf_pkg::idx_lsb +: pf_pkg::idx_w];
    assign rd_pc_idx   = lookup.pc[pf_pkg::idx_lsb +: pf_pkg::idx_w];
    assign wr_addr_idx = cwrite.addr[pf_pkg::idx_lsb +: pf_pkg::idx_w];
    assign wr_pc_idx   = cwrite.pc[pf_pkg::idx_lsb +: pf_pkg::idx_w];

    // hit follows the data address
    pf_table_ram #(
        .data_w (2),
        .init   (pf_pkg::hit_init)
    ) hit_ram_i (
        .clk    (clk),
        .arst_n (arst_n),
        .raddr  (rd_addr_idx),
        .rdata  (hit_rd),
        .we     (cwrite.we),
        .waddr  (wr_addr_idx),
        .wdata  (cwrite.counters.hit)
    );

    // spare and choice follow the pc
    pf_table_ram #(
        .data_w (2),
        .init   (pf_pkg::spare_init)
    ) spare_ram_i (
        .clk    (clk),
        .arst_n (arst_n),
        .raddr  (rd_pc_idx),
        .rdata  (spare_rd),
        .we     (cwrite.we),
        .waddr  (wr_pc_idx),
        .wdata  (cwrite.counters.spare)
    );

    pf_table_ram #(
        .data_w (2),
        .init   (pf_pkg::choice_init)
    ) choice_ram_i (
        .clk    (clk),
        .arst_n (arst_n),
        .raddr  (rd_pc_idx),
        .rdata  (choice_rd),
        .we     (cwrite.we),
        .waddr  (wr_pc_idx),
        .wdata  (cwrite.counters.choice)
    );

    always_comb begin
        counters.hit    = hit_rd;
        counters.spare  = spare_rd;
        counters.choice = choice_rd;
    end

endmodule

// File: rtl/pf_result_select.sv
`timescale 1ns/1ps

module pf_result_select (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      acc_valid,
    input  logic                      suppress,
    input  logic                      stride_valid,
    input  logic [pf_pkg::addr_w-1:0] stride_addr,
    input  logic                      ptr_valid,
    input  logic [pf_pkg::addr_w-1:0] ptr_addr,
    input  pf_pkg::pf_counters_t      counters,
    output logic                      pred_valid,
    output pf_pkg::pf_pred_t          pred
);

    logic                      acc_valid_q;
    logic                      use_ptr;
    logic                      src_valid;
    logic [pf_pkg::addr_w-1:0] src_addr;
    logic                      issue;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            acc_valid_q <= 1'b0;
        end else begin
            acc_valid_q <= acc_valid;
        end
    end

    // choice msb picks the pointer predictor
    assign use_ptr   = counters.choice[1];
    assign src_valid = use_ptr ? ptr_valid : stride_valid;
    assign src_addr  = use_ptr ? ptr_addr : stride_addr;

    // likely uncached and bandwidth free
    assign issue = acc_valid_q && !suppress && !counters.hit[1]
                   && counters.spare[1] && src_valid;

    assign pred_valid = issue;

    always_comb begin
        pred.addr     = issue ? src_addr : '0;
        pred.counters = counters;
    end

endmodule

// File: rtl/data_prefetch_top.sv
`timescale 1ns/1ps

module data_prefetch_top (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               acc_valid,
    input  pf_pkg::pf_access_t acc,
    input  logic               upd_valid,
    input  pf_pkg::pf_update_t upd,
    input  logic               ann_valid,
    input  pf_pkg::pf_anneal_t ann,
    output logic               pred_valid,
    output pf_pkg::pf_pred_t   pred
);

    pf_pkg::pf_lookup_t        lookup;
    pf_pkg::pf_cwrite_t        cwrite;
    pf_pkg::pf_counters_t      counters;
    logic                      suppress_q;
    logic                      stride_valid;
    logic [pf_pkg::addr_w-1:0] stride_addr;
    logic                      ptr_valid;
    logic [pf_pkg::addr_w-1:0] ptr_addr;

    pf_request_decode decode_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .acc_valid   (acc_valid),
        .acc         (acc),
        .upd_valid   (upd_valid),
        .upd         (upd),
        .ann_valid   (ann_valid),
        .ann         (ann),
        .rd_counters (counters),
        .lookup      (lookup),
        .cwrite      (cwrite),
        .suppress_q  (suppress_q)
    );

    // next-address predictors see every access
    pf_stride_table stride_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .acc_valid    (acc_valid),
        .acc          (acc),
        .stride_valid (stride_valid),
        .stride_addr  (stride_addr)
    );

    pf_pointer_table pointer_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .acc_valid (acc_valid),
        .acc       (acc),
        .ptr_valid (ptr_valid),
        .ptr_addr  (ptr_addr)
    );

    pf_confidence_table confidence_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .lookup   (lookup),
        .cwrite   (cwrite),
        .counters (counters)
    );

    pf_result_select result_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .acc_valid    (acc_valid),
        .suppress     (suppress_q),
        .stride_valid (stride_valid),
        .stride_addr  (stride_addr),
        .ptr_valid    (ptr_valid),
        .ptr_addr     (ptr_addr),
        .counters     (counters),
        .pred_valid   (pred_valid),
        .pred         (pred)
    );

endmodule

// File: verif/tb_data_prefetch.sv
`timescale 1ns/1ps

module tb_data_prefetch;

    localparam int depth           = 1 << pf_pkg::idx_w;
    localparam int reset_cycles    = 10;
    localparam int directed_cycles = 64;
    localparam int rand_cycles     = 2000;
    localparam int cycle_limit     = 2 * (reset_cycles + directed_cycles + rand_cycles);

    logic                 clk;
    logic                 arst_n;
    logic                 acc_valid;
    pf_pkg::pf_access_t   acc;
    logic                 upd_valid;
    pf_pkg::pf_update_t   upd;
    logic                 ann_valid;
    pf_pkg::pf_anneal_t   ann;
    logic                 pred_valid;
    pf_pkg::pf_pred_t     pred;

    // reference tables
    pf_pkg::ctr_t         hit_m [depth];
    pf_pkg::ctr_t         spare_m [depth];
    pf_pkg::ctr_t         choice_m [depth];
    logic [31:0]          slast_m [depth];
    logic                 sval_m [depth];
    logic [31:0]          pnext_m [depth];
    logic                 pval_m [depth];
    logic [31:0]          prev_addr_m;
    logic                 ann_pend_m;
    pf_pkg::pf_anneal_t   ann_m;
    pf_pkg::pf_counters_t rd_m;

    logic                 have_exp;
    logic                 exp_valid;
    logic [31:0]          exp_addr;
    pf_pkg::pf_counters_t exp_ctr;

    logic [31:0]          lfsr = 32'h8802d73b;
    int                   cycle_count = 0;

    data_prefetch_top dut_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .acc_valid  (acc_valid),
        .acc        (acc),
        .upd_valid  (upd_valid),
        .upd        (upd),
        .ann_valid  (ann_valid),
        .ann        (ann),
        .pred_valid (pred_valid),
        .pred       (pred)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic report_fail(input string msg);
        $display("%s", msg);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic logic [5:0] table_index(input logic [31:0] a);
        return a[pf_pkg::idx_lsb +: pf_pkg::idx_w];
    endfunction

    // 2-bit saturating counter rule
    function automatic pf_pkg::ctr_t sat_step(input pf_pkg::ctr_t c, input logic taken);
        if (taken) begin
            return (c == 2'b11) ? c : c + 2'd1;
        end
        return (c == 2'b00) ? c : c - 2'd1;
    endfunction

    function automatic pf_pkg::pf_counters_t model_snapshot(input logic [31:0] pc,
                                                            input logic [31:0] addr);
        return {hit_m[table_index(addr)], spare_m[table_index(pc)], choice_m[table_index(pc)]};
    endfunction

    task automatic clear_model();
        for (int i = 0; i < depth; i++) begin
            hit_m[i]    = pf_pkg::hit_init;
            spare_m[i]  = pf_pkg::spare_init;
            choice_m[i] = pf_pkg::choice_init;
            sval_m[i]   = 1'b0;
            pval_m[i]   = 1'b0;
            slast_m[i]  = '0;
            pnext_m[i]  = '0;
        end
        prev_addr_m = '0;
        ann_pend_m  = 1'b0;
        have_exp    = 1'b0;
    endtask

    // one reference cycle reads old entries before writing
    task automatic model_cycle();
        logic [31:0]          lpc;
        logic [31:0]          laddr;
        logic [31:0]          s_addr;
        logic                 use_ptr;
        logic                 src_ok;
        pf_pkg::pf_counters_t rd;
        lpc       = ann_valid ? ann.pc : acc.pc;
        laddr     = ann_valid ? ann.addr : acc.addr;
        rd.hit    = hit_m[table_index(laddr)];
        rd.spare  = spare_m[table_index(lpc)];
        rd.choice = choice_m[table_index(lpc)];
        use_ptr   = rd.choice[1];
        src_ok    = use_ptr ? pval_m[table_index(acc.addr)] : sval_m[table_index(acc.pc)];
        s_addr    = acc.addr + (acc.addr - slast_m[table_index(acc.pc)]);
        exp_valid = acc_valid && !ann_valid && !rd.hit[1] && rd.spare[1] && src_ok;
        if (!exp_valid) begin
            exp_addr = '0;
        end else begin
            exp_addr = use_ptr ? pnext_m[table_index(acc.addr)] : s_addr;
        end
        exp_ctr  = rd;
        have_exp = 1'b1;
        if (ann_pend_m) begin
            hit_m[table_index(ann_m.addr)]  = sat_step(rd_m.hit, 1'b0);
            spare_m[table_index(ann_m.pc)]  = sat_step(rd_m.spare, 1'b1);
            choice_m[table_index(ann_m.pc)] = rd_m.choice;
        end else if (upd_valid) begin
            hit_m[table_index(upd.addr)]  = sat_step(upd.counters.hit, upd.hit);
            spare_m[table_index(upd.pc)]  = sat_step(upd.counters.spare, upd.spare);
            choice_m[table_index(upd.pc)] = sat_step(upd.counters.choice, upd.choice);
        end
        if (acc_valid) begin
            slast_m[table_index(acc.pc)] = acc.addr;
            sval_m[table_index(acc.pc)]  = 1'b1;
            if (acc.addr != prev_addr_m) begin
                pnext_m[table_index(prev_addr_m)] = acc.addr;
                pval_m[table_index(prev_addr_m)]  = 1'b1;
            end
            prev_addr_m = acc.addr;
        end
        ann_pend_m = ann_valid;
        if (ann_valid) begin
            ann_m = ann;
        end
        rd_m = rd;
    endtask

    // outputs are stable at the falling edge
    always @(negedge clk) begin
        if (!arst_n) begin
            clear_model();
        end else begin
            if (have_exp) begin
                assert (pred_valid === exp_valid) else report_fail($sformatf(
                    "MISMATCH pred_valid got %h expected %h", pred_valid, exp_valid));
                assert (pred.addr === exp_addr) else report_fail($sformatf(
                    "MISMATCH pred.addr got %h expected %h", pred.addr, exp_addr));
                assert (pred.counters === exp_ctr) else report_fail($sformatf(
                    "MISMATCH pred.counters got %h expected %h", pred.counters, exp_ctr));
            end
            model_cycle();
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            report_fail($sformatf("timeout, run went past %0d cycles", cycle_limit));
        end
    end

    task automatic drive(input logic av, input pf_pkg::pf_access_t a, input logic uv,
                         input pf_pkg::pf_update_t u, input logic nv,
                         input pf_pkg::pf_anneal_t n);
        @(posedge clk);
        acc_valid <= av;
        acc       <= a;
        upd_valid <= uv;
        upd       <= u;
        ann_valid <= nv;
        ann       <= n;
    endtask

    task automatic idle();
        drive(1'b0, '0, 1'b0, '0, 1'b0, '0);
    endtask

    task automatic access(input logic [31:0] pc, input logic [31:0] addr);
        drive(1'b1, {pc, addr}, 1'b0, '0, 1'b0, '0);
    endtask

    // snapshot read at the edge, after the previous cycle is in the model
    task automatic update(input logic [31:0] pc, input logic [31:0] addr,
                          input logic h, input logic s, input logic c);
        @(posedge clk);
        acc_valid <= 1'b0;
        acc       <= '0;
        upd_valid <= 1'b1;
        upd       <= {pc, addr, h, s, c, model_snapshot(pc, addr)};
        ann_valid <= 1'b0;
        ann       <= '0;
    endtask

    initial begin
        logic [31:0] pc;
        logic [31:0] addr;
        logic [2:0]  outcome;
        arst_n    = 1'b0;
        acc_valid = 1'b0;
        acc       = '0;
        upd_valid = 1'b0;
        upd       = '0;
        ann_valid = 1'b0;
        ann       = '0;
        repeat (reset_cycles) @(posedge clk);
        arst_n <= 1'b1;
        idle();

        // stride predictor trains on the first access of a pc
        access(32'h1000, 32'h1_0100);
        access(32'h1000, 32'h1_0140);
        access(32'h1000, 32'h1_0180);
        idle();

        // switch pc 2004 to the pointer predictor and walk a chain
        update(32'h2004, 32'h2_0000, 1'b0, 1'b1, 1'b1);
        update(32'h2004, 32'h2_0000, 1'b0, 1'b1, 1'b1);
        repeat (3) begin
            access(32'h2004, 32'h3_0010);
            access(32'h2004, 32'h3_0024);
            access(32'h2004, 32'h3_0038);
            access(32'h2004, 32'h3_004c);
        end

        // likely-cached line blocks the prediction until trained back
        update(32'h1000, 32'h1_01c0, 1'b1, 1'b1, 1'b0);
        update(32'h1000, 32'h1_01c0, 1'b1, 1'b1, 1'b0);
        access(32'h1000, 32'h1_01c0);
        update(32'h1000, 32'h1_01c0, 1'b0, 1'b1, 1'b0);
        update(32'h1000, 32'h1_01c0, 1'b0, 1'b1, 1'b0);
        access(32'h1000, 32'h1_0180);
        access(32'h1000, 32'h1_01c0);

        // anneal steals the slot and the colliding update is dropped
        drive(1'b1, {32'h1000, 32'h1_0200}, 1'b0, '0, 1'b1, {32'h1008, 32'h1_01c0});
        update(32'h1008, 32'h1_01c0, 1'b1, 1'b1, 1'b1);
        access(32'h1008, 32'h1_01c0);
        access(32'h1000, 32'h1_0200);
        access(32'h1000, 32'h1_0240);
        idle();

        // mixed traffic over small pc and address pools
        repeat (rand_cycles) begin
            @(posedge clk);
            acc_valid <= (rand_bits(2) != 0);
            acc       <= {32'h1000 + (rand_bits(2) << 2), 32'h4000 + (rand_bits(8) << 2)};
            pc        = 32'h1000 + (rand_bits(2) << 2);
            addr      = 32'h4000 + (rand_bits(8) << 2);
            upd_valid <= (rand_bits(2) == 0);
            outcome   = rand_bits(3);
            upd       <= {pc, addr, outcome, model_snapshot(pc, addr)};
            ann_valid <= (rand_bits(3) == 0);
            ann       <= {32'h1000 + (rand_bits(2) << 2), 32'h4000 + (rand_bits(8) << 2)};
        end

        repeat (4) idle();
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// File: all.f
rtl/pf_pkg.sv
rtl/pf_table_ram.sv
rtl/pf_request_decode.sv
rtl/pf_stride_table.sv
rtl/pf_pointer_table.sv
rtl/pf_confidence_table.sv
rtl/pf_result_select.sv
rtl/data_prefetch_top.sv
verif/tb_data_prefetch.sv

// File: Bender.yml
package:
  name: data_prefetch

sources:
  - files:
      - rtl/pf_pkg.sv
      - rtl/pf_table_ram.sv
      - rtl/pf_request_decode.sv
      - rtl/pf_stride_table.sv
      - rtl/pf_pointer_table.sv
      - rtl/pf_confidence_table.sv
      - rtl/pf_result_select.sv
      - rtl/data_prefetch_top.sv
  - target: test
    files:
      - verif/tb_data_prefetch.sv
